//--- rv_core.f
rv_pkg.sv
rv_ctrl_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f rv_core.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int IMEM_WORDS = 256;    // 1 KiB of code
    localparam int DMEM_WORDS = 64;     // data window 0x00..0xfc
    localparam int MAX_CYCLES = 2000;   // bound on one program run
    localparam int DUMP_BASE  = 128;    // register dump area

    // program kinds
    localparam int K_ALU  = 0;
    localparam int K_FLOW = 1;
    localparam int K_LOAD = 2;
    localparam int K_ILL  = 3;
    localparam int K_X0   = 4;

    logic           CLK;
    logic           RESET;
    rv_pkg::xlen_t  instr_addr;
    rv_pkg::instr_t instr;
    logic           mem_req;
    logic           mem_we;
    rv_pkg::xlen_t  mem_addr;
    rv_pkg::xlen_t  mem_wdata;
    rv_pkg::xlen_t  mem_rdata;
    logic           illegal;

    rv_pkg::instr_t imem [IMEM_WORDS];
    rv_pkg::xlen_t  dmem [DMEM_WORDS];
    rv_pkg::xlen_t  m_regs [32];         // reference model state
    rv_pkg::xlen_t  m_dmem [DMEM_WORDS];
    rv_pkg::xlen_t  m_pc;
    rv_pkg::xlen_t  end_pc;              // first address past the dump
    int             test_errors;
    int             tests_run;
    int             tests_failed;
    int             total_errors;

    rv_core u_rv_core (
        .CLK             (CLK),
        .RESET           (RESET),
        .instr_addr_o    (instr_addr),
        .instr_i         (instr),
        .mem_req_o       (mem_req),
        .mem_we_o        (mem_we),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .mem_rdata_i     (mem_rdata),
        .illegal_instr_o (illegal)
    );

    ////////////////////
    // memories around the core
    assign instr     = imem[instr_addr[9:2]];   // same-cycle fetch
    assign mem_rdata = dmem[mem_addr[7:2]];

    always @(posedge CLK) begin
        if (mem_req && mem_we) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check_value(input string what, input rv_pkg::xlen_t exp,
                               input rv_pkg::xlen_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", what, exp, act);
            test_errors++;
        end
    endtask

    ////////////////////
    // instruction encoders
    function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};  // sw rs2, imm(x0)
    endfunction

    function automatic rv_pkg::instr_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // random legal op, op_imm, lui or auipc
    function automatic rv_pkg::instr_t gen_alu();
        logic [31:0] r;
        logic [6:0]  f7;
        r = $urandom;
        case ($urandom % 4)
            0: begin
                f7 = ((r[14:12] == 3'd0 || r[14:12] == 3'd5) && r[30]) ? 7'h20 : 7'h00;
                gen_alu = {f7, r[24:7], 7'b0110011};
            end
            1: begin
                if (r[14:12] == 3'd1) f7 = 7'h00;                   // slli
                else if (r[14:12] == 3'd5) f7 = r[30] ? 7'h20 : 7'h00;  // srli or srai
                else f7 = r[31:25];                                 // plain immediate
                gen_alu = {f7, r[24:7], 7'b0010011};
            end
            2: gen_alu = {r[31:7], 7'b0110111};
            default: gen_alu = {r[31:7], 7'b0010111};
        endcase
    endfunction

    function automatic rv_pkg::instr_t gen_illegal();
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $urandom;
        f3 = (r[14:12] == 3'b010) ? 3'b011 : r[14:12];  // anything but word
        case ($urandom % 6)
            0: gen_illegal = {r[31:7], r[0] ? 7'b0001111 : 7'b1110011};  // fence or system
            1: gen_illegal = {r[31:15], 2'b01, r[12:7], 7'b1100011};     // branch f3 01x
            2: gen_illegal = {r[31:15], f3, r[11:7], 7'b0000011};
            3: gen_illegal = {r[31:15], f3, r[11:7], 7'b0100011};
            4: gen_illegal = {r[31:25] | 7'h01, r[24:7], 7'b0110011};    // bad funct7
            default: gen_illegal = {r[31:25] | 7'h01, r[24:15], 3'b001, r[11:7], 7'b0010011};
        endcase
    endfunction

    ////////////////////
    // reference model of the rv32i rules
    function automatic rv_pkg::xlen_t alu_calc(input logic [2:0] f3, input logic alt,
                                               input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        case (f3)
            3'd0: alu_calc = alt ? a - b : a + b;
            3'd1: alu_calc = a << b[4:0];
            3'd2: alu_calc = {31'd0, $signed(a) < $signed(b)};
            3'd3: alu_calc = {31'd0, a < b};
            3'd4: alu_calc = a ^ b;
            3'd5: begin
                if (alt) alu_calc = $signed(a) >>> b[4:0];  // keep sign
                else alu_calc = a >> b[4:0];
            end
            3'd6: alu_calc = a | b;
            default: alu_calc = a & b;
        endcase
    endfunction

    task automatic model_step(input rv_pkg::instr_t ins, output logic e_req, output logic e_we,
                              output rv_pkg::xlen_t e_addr, output rv_pkg::xlen_t e_wdata,
                              output logic e_ill);
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic          wr;
        logic          taken;
        rv_pkg::xlen_t a;
        rv_pkg::xlen_t b;
        rv_pkg::xlen_t imm_i;
        rv_pkg::xlen_t imm_u;
        rv_pkg::xlen_t res;
        rv_pkg::xlen_t pc_next;
        f3      = ins[14:12];
        f7      = ins[31:25];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_u   = {ins[31:12], 12'd0};
        pc_next = m_pc + 32'd4;
        res     = '0;
        wr      = 1'b0;
        taken   = 1'b0;
        e_req   = 1'b0;
        e_we    = 1'b0;
        e_addr  = '0;
        e_wdata = '0;
        e_ill   = 1'b0;
        case (ins[6:0])
            rv_pkg::OPC_OP: begin
                e_ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                res   = alu_calc(f3, f7[5], a, b);
                wr    = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                e_ill = (f3 == 3'd1 && f7 != 7'h00) ||
                        (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                res   = alu_calc(f3, f3 == 3'd5 && f7[5], a, imm_i);
                wr    = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                res = imm_u;
                wr  = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                res = m_pc + imm_u;
                wr  = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                res     = m_pc + 32'd4;  // link
                wr      = 1'b1;
                pc_next = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                e_ill   = (f3 != 3'd0);
                res     = m_pc + 32'd4;
                wr      = 1'b1;
                pc_next = (a + imm_i) & ~32'd1;
            end
            rv_pkg::OPC_BRANCH: begin
                e_ill = (f3 == 3'd2) || (f3 == 3'd3);
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    pc_next = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rv_pkg::OPC_LOAD: begin
                e_ill  = (f3 != 3'b010);
                e_req  = 1'b1;
                e_addr = a + imm_i;
                res    = m_dmem[e_addr[7:2]];
                wr     = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                e_ill   = (f3 != 3'b010);
                e_req   = 1'b1;
                e_we    = 1'b1;
                e_addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                e_wdata = b;
            end
            default: e_ill = 1'b1;
        endcase
        if (e_ill) begin    // falls through as a nop
            e_req   = 1'b0;
            e_we    = 1'b0;
            wr      = 1'b0;
            pc_next = m_pc + 32'd4;
        end
        if (e_we) m_dmem[e_addr[7:2]] = e_wdata;
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
        m_pc = pc_next;
    endtask

    ////////////////////
    // program builder puts a store of every register after the body
    task automatic build_program(input int kind, input int body_len);
        int          t;
        logic [2:0]  bf3;
        logic [11:0] off;
        logic [4:0]  dst;
        off = '0;
        dst = '0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {12'(i), 20'h0_0013};  // addi x0, x0, i
        end
        for (int i = 0; i < body_len; i++) begin
            case (kind)
                K_FLOW: begin
                    t   = i + 1 + int'($urandom % (body_len - i));  // forward only
                    bf3 = 3'($urandom % 6);
                    if (bf3 > 3'd1) bf3 = bf3 + 3'd2;  // skip reserved 010 and 011
                    case ($urandom % 5)
                        0: imem[i] = enc_b(13'((t - i) * 4), 5'($urandom), 5'($urandom), bf3);
                        1: imem[i] = enc_j(21'((t - i) * 4), 5'($urandom));
                        2: imem[i] = enc_i(12'(t * 4 + int'($urandom % 2)), 5'd0, 3'b000,
                                           5'($urandom), 7'b1100111);  // odd target too
                        default: imem[i] = gen_alu();
                    endcase
                end
                K_LOAD: begin
                    case (i % 4)
                        0: imem[i] = gen_alu();
                        1: begin
                            off     = 12'(($urandom % 32) * 4);
                            dst     = 5'($urandom);
                            imem[i] = enc_s(off, 5'($urandom));
                        end
                        2: imem[i] = enc_i(off, 5'd0, 3'b010, dst, 7'b0000011);  // lw back
                        default: imem[i] = enc_s(12'(($urandom % 32) * 4), dst);
                    endcase
                end
                K_ILL:   imem[i] = ($urandom % 2 == 0) ? gen_illegal() : gen_alu();
                K_X0:    imem[i] = gen_alu() & 32'hFFFF_F07F;  // rd forced to x0
                default: imem[i] = gen_alu();
            endcase
        end
        for (int r = 0; r < 32; r++) begin
            imem[body_len + r] = enc_s(12'(DUMP_BASE + 4 * r), 5'(r));
        end
        end_pc = 32'((body_len + 32) * 4);
    endtask

    task automatic init_memories();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]   <= 32'hD00D_0000 | 32'(i * 4);  // tagged with byte address
            m_dmem[i] = 32'hD00D_0000 | 32'(i * 4);
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc = 32'h0;
    endtask

    // reset then step DUT and model together until the program ends
    task automatic run_test(input string name, input int kind, input int body_len);
        int            cyc;
        logic          lost;
        logic          e_req;
        logic          e_we;
        logic          e_ill;
        rv_pkg::xlen_t e_addr;
        rv_pkg::xlen_t e_wdata;
        test_errors = 0;
        cyc         = 0;
        lost        = 1'b0;
        RESET       = 1'b1;
        build_program(kind, body_len);
        init_memories();
        for (int n = 0; n < 5; n++) begin
            @(negedge CLK);
            if (n > 0) check_value({name, " reset fetch address"}, 32'h0, instr_addr);
            check_value({name, " reset mem_req"}, 32'h0, 32'(mem_req));
            check_value({name, " reset mem_we"}, 32'h0, 32'(mem_we));
            check_value({name, " reset illegal"}, 32'h0, 32'(illegal));
            @(posedge CLK);
            #2;
        end
        RESET = 1'b0;
        while (!lost && m_pc != end_pc && cyc < MAX_CYCLES) begin
            @(negedge CLK);  // outputs settled mid cycle
            check_value({name, " fetch address"}, m_pc, instr_addr);
            lost = (instr_addr !== m_pc);
            if (!lost) begin
                model_step(imem[m_pc[9:2]], e_req, e_we, e_addr, e_wdata, e_ill);
                check_value({name, " illegal"}, 32'(e_ill), 32'(illegal));
                check_value({name, " mem_req"}, 32'(e_req), 32'(mem_req));
                check_value({name, " mem_we"}, 32'(e_we), 32'(mem_we));
                if (e_req) check_value({name, " mem address"}, e_addr, mem_addr);
                if (e_we) check_value({name, " store data"}, e_wdata, mem_wdata);
            end
            @(posedge CLK);
            #2;
            cyc++;
        end
        if (!lost && m_pc != end_pc) begin
            $display("timeout in %s, program end not reached in %0d cycles", name, MAX_CYCLES);
            test_errors++;
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok after %0d cycles", name, cyc);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(68501));  // fixed seed
        RESET        = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        test_errors  = 0;
        end_pc       = '0;
        build_program(K_ALU, 1);
        init_memories();
        @(posedge CLK);
        #2;
        run_test("reset", K_ALU, 4);
        run_test("alu", K_ALU, 60);
        run_test("control_flow", K_FLOW, 80);
        run_test("loads", K_LOAD, 60);
        run_test("illegal", K_ILL, 60);
        run_test("x0", K_X0, 40);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic           CLK,
    input  logic           RESET,
    // instruction port, data back in same cycle
    output rv_pkg::xlen_t  instr_addr_o,
    input  rv_pkg::instr_t instr_i,
    // data port, no wait states
    output logic           mem_req_o,
    output logic           mem_we_o,     // 1 write, 0 read
    output rv_pkg::xlen_t  mem_addr_o,
    output rv_pkg::xlen_t  mem_wdata_o,
    input  rv_pkg::xlen_t  mem_rdata_i,
    output logic           illegal_instr_o
);

    rv_pkg::reg_addr_t ra1;
    rv_pkg::reg_addr_t ra2;
    rv_pkg::reg_addr_t wa;
    rv_pkg::xlen_t     rd1;
    rv_pkg::xlen_t     rd2;
    rv_pkg::xlen_t     rf_wd;   // writeback data from execute
    logic              rf_we;

    // register fields of the fetched word
    assign ra1 = instr_i[19:15];
    assign ra2 = instr_i[24:20];
    assign wa  = instr_i[11:7];

    rv_ctrl_if u_ctrl_if ();

    ////////////////////
    // decode and register read side by side
    rv_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl    (u_ctrl_if.decoder_mp)
    );

    rv_regfile u_regfile (
        .CLK   (CLK),
        .RESET (RESET),
        .ra1_i (ra1),
        .ra2_i (ra2),
        .wa_i  (wa),
        .wd_i  (rf_wd),
        .we_i  (rf_we),
        .rd1_o (rd1),
        .rd2_o (rd2)
    );

    rv_execute u_execute (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr_i     (instr_i),
        .ctrl        (u_ctrl_if.execute_mp),
        .rd1_i       (rd1),
        .rd2_i       (rd2),
        .rf_wd_o     (rf_wd),
        .rf_we_o     (rf_we),
        .pc_o        (instr_addr_o),   // fetch address is the pc
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .illegal_o   (illegal_instr_o)
    );

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
    input  logic           CLK,
    input  logic           RESET,
    input  rv_pkg::instr_t instr_i,
    rv_ctrl_if.execute_mp  ctrl,
    input  rv_pkg::xlen_t  rd1_i,
    input  rv_pkg::xlen_t  rd2_i,
    output rv_pkg::xlen_t  rf_wd_o,
    output logic           rf_we_o,
    output rv_pkg::xlen_t  pc_o,
    output logic           mem_req_o,
    output logic           mem_we_o,
    output rv_pkg::xlen_t  mem_addr_o,
    output rv_pkg::xlen_t  mem_wdata_o,
    input  rv_pkg::xlen_t  mem_rdata_i,
    output logic           illegal_o
);

    rv_pkg::xlen_t pc_q;         // only state outside the regfile
    rv_pkg::xlen_t pc_next;
    rv_pkg::xlen_t pc_plus4;
    rv_pkg::xlen_t jalr_sum;     // rs1 plus imm_i before alignment
    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_s;
    rv_pkg::xlen_t imm_b;
    rv_pkg::xlen_t imm_u;
    rv_pkg::xlen_t imm_j;
    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_result;
    logic          alu_flag;

    ////////////////////
    // immediates, sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // operand select
    always_comb begin
        case (ctrl.op_a_sel)
            rv_pkg::OPA_RS1: op_a = rd1_i;
            rv_pkg::OPA_PC:  op_a = pc_q;
            default:         op_a = '0;     // lui
        endcase
        case (ctrl.op_b_sel)
            rv_pkg::OPB_RS2:   op_b = rd2_i;
            rv_pkg::OPB_IMM_I: op_b = imm_i;
            rv_pkg::OPB_IMM_U: op_b = imm_u;
            rv_pkg::OPB_IMM_S: op_b = imm_s;
            rv_pkg::OPB_FOUR:  op_b = rv_pkg::PC_STEP;  // jal/jalr link
            default:           op_b = '0;
        endcase
    end

    rv_alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

    ////////////////////
    // writeback and data port
    assign rf_wd_o     = (ctrl.wb_sel == rv_pkg::WB_LOAD) ? mem_rdata_i : alu_result;
    assign rf_we_o     = ctrl.rf_we & ~RESET;
    assign mem_req_o   = ctrl.mem_req & ~RESET;
    assign mem_we_o    = ctrl.mem_req & ctrl.mem_we & ~RESET;
    assign mem_addr_o  = alu_result;   // rs1 + offset
    assign mem_wdata_o = rd2_i;        // full word store
    assign illegal_o   = ctrl.illegal & ~RESET;

    // next pc
    assign pc_plus4 = pc_q + rv_pkg::PC_STEP;
    assign jalr_sum = rd1_i + imm_i;

    always_comb begin
        if (ctrl.is_branch && alu_flag) begin
            pc_next = pc_q + imm_b;                 // taken branch
        end else if (ctrl.is_jal) begin
            pc_next = pc_q + imm_j;
        end else if (ctrl.is_jalr) begin
            pc_next = {jalr_sum[31:1], 1'b0};       // bit 0 cleared
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= rv_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;   // one instruction per edge
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  rv_pkg::xlen_t   a_i,
    input  rv_pkg::xlen_t   b_i,
    output rv_pkg::xlen_t   result_o,
    output logic            flag_o     // branch condition
);

    logic [4:0] shamt;   // shift amount from low bits of b

    assign shamt = b_i[4:0];

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SLT:  result_o = rv_pkg::xlen_t'($signed(a_i) < $signed(b_i));
            rv_pkg::ALU_SLTU: result_o = rv_pkg::xlen_t'(a_i < b_i);
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;  // sign fill
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            ////////////////////
            // branch compares
            rv_pkg::ALU_EQ:   flag_o = (a_i == b_i);
            rv_pkg::ALU_NE:   flag_o = (a_i != b_i);
            rv_pkg::ALU_LT:   flag_o = ($signed(a_i) < $signed(b_i));
            rv_pkg::ALU_GE:   flag_o = ($signed(a_i) >= $signed(b_i));
            rv_pkg::ALU_LTU:  flag_o = (a_i < b_i);
            rv_pkg::ALU_GEU:  flag_o = (a_i >= b_i);
            default: begin
                result_o = '0;
                flag_o   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic              CLK,
    input  logic              RESET,
    input  rv_pkg::reg_addr_t ra1_i,
    input  rv_pkg::reg_addr_t ra2_i,
    input  rv_pkg::reg_addr_t wa_i,
    input  rv_pkg::xlen_t     wd_i,
    input  logic              we_i,
    output rv_pkg::xlen_t     rd1_o,
    output rv_pkg::xlen_t     rd2_o
);

    rv_pkg::xlen_t regs [1:31];  // x0 has no storage

    // combinational reads, x0 reads zero
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin  // drop x0 writes
            regs[wa_i] <= wd_i;
        end
    end

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::instr_t instr_i,
    rv_ctrl_if.decoder_mp  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;     // raw illegal flag

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to alu op
    // alt bit picks sub and sra
    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_pkg::F3_ADD_SUB: arith_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     arith_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     arith_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    arith_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     arith_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      arith_op = rv_pkg::ALU_OR;
            default:            arith_op = rv_pkg::ALU_AND;  // F3_AND
        endcase
    endfunction

    always_comb begin
        // nop defaults
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.op_a_sel  = rv_pkg::OPA_RS1;
        ctrl.op_b_sel  = rv_pkg::OPB_RS2;
        ctrl.wb_sel    = rv_pkg::WB_ALU;
        ctrl.rf_we     = 1'b0;
        ctrl.mem_req   = 1'b0;
        ctrl.mem_we    = 1'b0;
        ctrl.is_branch = 1'b0;
        ctrl.is_jal    = 1'b0;
        ctrl.is_jalr   = 1'b0;
        bad            = 1'b0;

        case (opcode)
            rv_pkg::OPC_OP: begin
                ctrl.alu_op = arith_op(funct3, funct7[5]);
                ctrl.rf_we  = 1'b1;
                if (funct7 == rv_pkg::F7_ALT) begin  // only sub and sra
                    bad = (funct3 != rv_pkg::F3_ADD_SUB) && (funct3 != rv_pkg::F3_SRL_SRA);
                end else begin
                    bad = (funct7 != rv_pkg::F7_BASE);
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.op_b_sel = rv_pkg::OPB_IMM_I;
                ctrl.rf_we    = 1'b1;
                if (funct3 == rv_pkg::F3_SLL) begin
                    ctrl.alu_op = rv_pkg::ALU_SLL;
                    bad         = (funct7 != rv_pkg::F7_BASE);
                end else if (funct3 == rv_pkg::F3_SRL_SRA) begin
                    ctrl.alu_op = arith_op(funct3, funct7[5]);
                    bad         = (funct7 != rv_pkg::F7_BASE) && (funct7 != rv_pkg::F7_ALT);
                end else begin
                    ctrl.alu_op = arith_op(funct3, 1'b0);  // no subi
                end
            end
            rv_pkg::OPC_LUI: begin
                ctrl.op_a_sel = rv_pkg::OPA_ZERO;  // 0 + imm_u
                ctrl.op_b_sel = rv_pkg::OPB_IMM_U;
                ctrl.rf_we    = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.op_a_sel = rv_pkg::OPA_PC;
                ctrl.op_b_sel = rv_pkg::OPB_IMM_U;
                ctrl.rf_we    = 1'b1;
            end
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin
                ctrl.op_a_sel = rv_pkg::OPA_PC;    // link value pc + 4
                ctrl.op_b_sel = rv_pkg::OPB_FOUR;
                ctrl.rf_we    = 1'b1;
                ctrl.is_jal   = (opcode == rv_pkg::OPC_JAL);
                ctrl.is_jalr  = (opcode == rv_pkg::OPC_JALR);
                bad           = ctrl.is_jalr && (funct3 != rv_pkg::F3_JALR);
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;  // rs1 vs rs2
                case (funct3)
                    rv_pkg::F3_BEQ:  ctrl.alu_op = rv_pkg::ALU_EQ;
                    rv_pkg::F3_BNE:  ctrl.alu_op = rv_pkg::ALU_NE;
                    rv_pkg::F3_BLT:  ctrl.alu_op = rv_pkg::ALU_LT;
                    rv_pkg::F3_BGE:  ctrl.alu_op = rv_pkg::ALU_GE;
                    rv_pkg::F3_BLTU: ctrl.alu_op = rv_pkg::ALU_LTU;
                    rv_pkg::F3_BGEU: ctrl.alu_op = rv_pkg::ALU_GEU;
                    default:         bad = 1'b1;  // reserved funct3
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                ctrl.op_b_sel = rv_pkg::OPB_IMM_I;
                ctrl.wb_sel   = rv_pkg::WB_LOAD;
                ctrl.rf_we    = 1'b1;
                ctrl.mem_req  = 1'b1;
                bad           = (funct3 != rv_pkg::F3_WORD);  // lw only
            end
            rv_pkg::OPC_STORE: begin
                ctrl.op_b_sel = rv_pkg::OPB_IMM_S;
                ctrl.mem_req  = 1'b1;
                ctrl.mem_we   = 1'b1;
                bad           = (funct3 != rv_pkg::F3_WORD);  // sw only
            end
            default: bad = 1'b1;  // fence, system and unknown
        endcase

        // illegal acts as a nop with pc + 4
        if (bad) begin
            ctrl.rf_we     = 1'b0;
            ctrl.mem_req   = 1'b0;
            ctrl.mem_we    = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
        ctrl.illegal = bad;
    end

endmodule

`default_nettype wire

//--- rv_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

// decoded control bundle, decoder to execute
interface rv_ctrl_if;

    rv_pkg::alu_op_e   alu_op;
    rv_pkg::op_a_sel_e op_a_sel;
    rv_pkg::op_b_sel_e op_b_sel;
    rv_pkg::wb_sel_e   wb_sel;
    logic              rf_we;      // register writeback
    logic              mem_req;    // data port access
    logic              mem_we;     // write when set
    logic              is_branch;  // conditional branch
    logic              is_jal;
    logic              is_jalr;
    logic              illegal;    // encoding outside the supported set

    modport decoder_mp (
        output alu_op, op_a_sel, op_b_sel, wb_sel, rf_we, mem_req, mem_we,
               is_branch, is_jal, is_jalr, illegal
    );

    modport execute_mp (
        input  alu_op, op_a_sel, op_b_sel, wb_sel, rf_we, mem_req, mem_we,
               is_branch, is_jal, is_jalr, illegal
    );

endinterface

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    ////////////////////
    // widths and word types
    localparam int XLEN   = 32;    // data path width
    localparam int REG_AW = 5;     // 32 architectural registers

    typedef logic [XLEN-1:0]   xlen_t;      // data word and address
    typedef logic [31:0]       instr_t;     // raw fetched instruction
    typedef logic [REG_AW-1:0] reg_addr_t;  // register index

    localparam xlen_t PC_STEP  = 32'd4;         // one instruction
    localparam xlen_t RESET_PC = 32'h0000_0000; // boot address

    ////////////////////
    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // reg-reg alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 for op and op_imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches, 010 and 011 are reserved
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw only
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub and sra

    ////////////////////
    // control encodings
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
        ALU_LT, ALU_GE, ALU_LTU, ALU_GEU     // compare ops drive the flag only
    } alu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2, OPB_IMM_I, OPB_IMM_U, OPB_IMM_S, OPB_FOUR
    } op_b_sel_e;

    typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;

endpackage

`default_nettype wire
